/* hdl/sdram_pkg.sv */
/*
  Shared types for the SDRAM controller and its chip model.
  Command codes, mode register layout, address bus views and bus structs.
  Pull in with a wildcard import inside the module body.
*/
package sdram_pkg;

  // ------------------------------
  // widths and constants
  // ------------------------------
  localparam int addr_w    = 24;  // cpu word address
  localparam int data_w    = 16;
  localparam int sd_addr_w = 13;  // multiplexed chip address
  localparam int init_len  = 25;  // power-up countdown start

  // chip commands as {cs, ras, cas, we}
  typedef enum logic [3:0] {
    cmd_inhibit         = 4'b1111,
    cmd_nop             = 4'b0111,
    cmd_active          = 4'b0011,
    cmd_read            = 4'b0101,
    cmd_write           = 4'b0100,
    cmd_burst_terminate = 4'b0110,
    cmd_precharge       = 4'b0010,
    cmd_auto_refresh    = 4'b0001,
    cmd_load_mode       = 4'b0000
  } sd_cmd_e;

  // what the address map puts on the bus next
  typedef enum logic [1:0] {
    ph_row, ph_col, ph_pre_all, ph_mode
  } phase_e;

  // cpu side, sampled straight at 100 MHz
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] din;
    logic              udsn;
    logic              ldsn;
    logic              asn;
    logic              rw;  // 1 = read
  } cpu_req_t;

  typedef struct packed {
    sd_cmd_e cmd;
    logic    cke;
  } sd_ctrl_t;

  // ------------------------------
  // address bus, two decodes
  // ------------------------------
  typedef union packed {
    struct packed {
      logic [2:0] reserved;
      logic       write_burst;  // 1 = single write
      logic [1:0] op_mode;      // 00 only
      logic [2:0] cas_lat;
      logic       access_type;  // 0 = sequential
      logic [2:0] burst_len;    // 001 = two words
    } mode;
    struct packed {
      logic [1:0] upper;
      logic       a10;          // auto-precharge
      logic [9:0] column;
    } col;
  } sd_addr_u;

endpackage

/* hdl/sdram_init.sv */
/*
  Power-up sequencer for the SDRAM chip.
  Counts down after reset, issues precharge-all then load-mode,
  and raises ready once the count runs out.
*/
`timescale 1ns/1ns

module sdram_init (
  input  logic              clk100_mhz,
  input  logic              rst,
  output sdram_pkg::sd_cmd_e cmd,
  output sdram_pkg::phase_e  phase,
  output logic              ready
);
  import sdram_pkg::*;

  localparam logic [4:0] cnt_pre  = 5'd20;  // precharge all banks
  localparam logic [4:0] cnt_mode = 5'd10;  // load mode register
  localparam logic [4:0] cnt_half = 5'd15;  // address switches to mode view below this

  logic [4:0] count;

  // ------------------------------
  // countdown
  // ------------------------------
  always_ff @(posedge clk100_mhz) begin
    if (rst) begin
      count <= 5'(init_len);  // held while in reset
    end else if (count != 5'd0) begin
      count <= count - 5'd1;
    end
  end

  // commands land on the pins one clock later, together with the address
  always_comb begin
    cmd = cmd_inhibit;  // quiet in between
    if (count == cnt_pre)
      cmd = cmd_precharge;
    else if (count == cnt_mode)
      cmd = cmd_load_mode;
  end

  assign phase = (count > cnt_half) ? ph_pre_all : ph_mode;
  assign ready = (count == 5'd0);  // chip usable from here

endmodule

/* hdl/sdram_addr_map.sv */
/*
  Address multiplexer for the chip address and bank pins.
  Splits the cpu word address into bank, row and column and
  registers whatever the current phase asks for.
*/
`timescale 1ns/1ns

module sdram_addr_map #(
  parameter int cas_latency = 3
) (
  input  logic                           clk100_mhz,
  input  logic [sdram_pkg::addr_w-1:0]   addr,
  input  sdram_pkg::phase_e              phase,
  output logic [sdram_pkg::sd_addr_w-1:0] sd_addr,
  output logic [1:0]                     sd_ba
);
  import sdram_pkg::*;

  sd_addr_u mode_word;
  sd_addr_u col_word;

  always_comb begin
    mode_word.mode.reserved    = 3'b000;
    mode_word.mode.write_burst = 1'b1;               // single-word writes
    mode_word.mode.op_mode     = 2'b00;
    mode_word.mode.cas_lat     = 3'(cas_latency);
    mode_word.mode.access_type = 1'b0;               // sequential
    mode_word.mode.burst_len   = 3'b001;             // 2 words
  end

  always_comb begin
    col_word.col.upper  = 2'b00;
    col_word.col.a10    = 1'b1;                          // close row after access
    col_word.col.column = {1'b0, addr[22], addr[7:0]};   // a22 extends the column
  end

  // one register stage, aligned with the command register
  always_ff @(posedge clk100_mhz) begin
    case (phase)
      ph_row: begin
        sd_addr <= {1'b0, addr[19:8]};
        sd_ba   <= addr[21:20];
      end
      ph_col: begin
        sd_addr <= col_word;
        sd_ba   <= addr[21:20];
      end
      ph_pre_all: begin
        sd_addr <= 13'h0400;  // a10 high, all banks
        sd_ba   <= 2'b00;
      end
      default: begin
        sd_addr <= mode_word;
        sd_ba   <= 2'b00;
      end
    endcase
  end

endmodule

/* hdl/sdram_data_path.sv */
/*
  Data side of the controller.
  Drives the tri-state chip data bus during writes, loads the byte masks,
  and latches read data into dout where it stays until the next read.
*/
`timescale 1ns/1ns

module sdram_data_path (
  input  logic                         clk100_mhz,
  input  logic                         rst,
  input  logic [sdram_pkg::data_w-1:0] din,
  input  logic                         udsn,
  input  logic                         ldsn,
  input  logic                         rw,
  input  logic                         wr_en,      // drive bus next cycle
  input  logic                         rd_strobe,  // capture this cycle
  input  logic                         mask_load,
  inout  wire  [sdram_pkg::data_w-1:0] sd_data,
  output logic [1:0]                   sd_dqm,
  output logic [sdram_pkg::data_w-1:0] dout
);

  logic drive;  // output enable of the data pins

  // ------------------------------
  // write side
  // ------------------------------
  always_ff @(posedge clk100_mhz) begin
    if (rst) begin
      drive  <= 1'b0;
      sd_dqm <= 2'b00;
    end else begin
      drive <= wr_en;
      if (mask_load)
        sd_dqm <= rw ? 2'b00 : {udsn, ldsn};  // reads take both bytes
    end
  end

  // cpu data goes straight out, it is stable for the whole strobe cycle
  assign sd_data = drive ? din : 'z;

  // ------------------------------
  // read side
  // ------------------------------
  always_ff @(posedge clk100_mhz) begin
    if (rd_strobe)
      dout <= sd_data;  // held across writes and refreshes
  end

endmodule

/* hdl/sdram_cycle_ctrl.sv */
/*
  Cycle sequencer of the SDRAM controller.
  Runs a step counter per cpu strobe cycle or idle refresh, issues the chip
  commands and steers the address map and data path. Before the chip is
  ready it passes the power-up commands through.
*/
`timescale 1ns/1ns

module sdram_cycle_ctrl #(
  parameter int rcd_cycles  = 2,
  parameter int cas_latency = 3
) (
  input  logic                clk100_mhz,
  input  logic                rst,
  input  sdram_pkg::cpu_req_t req,
  input  logic                ready,
  input  sdram_pkg::sd_cmd_e  init_cmd,
  input  sdram_pkg::phase_e   init_phase,
  output sdram_pkg::sd_ctrl_t ctrl,
  output sdram_pkg::phase_e   phase,
  output logic                wr_en,
  output logic                rd_strobe,
  output logic                mask_load
);
  import sdram_pkg::*;

  // ------------------------------
  // step numbering
  // ------------------------------
  localparam int cas_i  = rcd_cycles;                    // read/write issue
  localparam int capt_i = rcd_cycles + cas_latency + 1;  // read data capture
  localparam int last_i = capt_i + 1;
  localparam int t_w    = $clog2(last_i + 1);

  localparam logic [t_w-1:0] first_step   = '0;
  localparam logic [t_w-1:0] cas_step     = t_w'(cas_i);
  localparam logic [t_w-1:0] setup_step   = t_w'(cas_i - 1);  // column, dqm, drive
  localparam logic [t_w-1:0] hold_step    = t_w'(cas_i + 2);  // cke low on reads
  localparam logic [t_w-1:0] capt_step    = t_w'(capt_i);
  localparam logic [t_w-1:0] last_step    = t_w'(last_i);

  logic [t_w-1:0] t;
  logic           memact;  // current cycle is a cpu access and not a refresh
  logic           memcyc;
  logic           block;

  assign memcyc = !req.asn && !(req.udsn && req.ldsn);  // strobe cycle under way
  assign block  = !req.asn && req.udsn && req.ldsn;     // write about to start

  // ------------------------------
  // counter and commands
  // ------------------------------
  always_ff @(posedge clk100_mhz) begin
    if (rst) begin
      t      <= first_step;
      memact <= 1'b0;
      ctrl   <= '{cmd: cmd_inhibit, cke: 1'b1};
    end else begin
      ctrl.cmd <= cmd_inhibit;  // default idle
      ctrl.cke <= 1'b1;

      if (!ready) begin
        t        <= first_step;
        ctrl.cmd <= init_cmd;  // power-up sequence
      end else begin
        if (t == first_step) begin
          if (memcyc) begin
            t        <= t + 1'b1;
            memact   <= 1'b1;
            ctrl.cmd <= cmd_active;  // row open
          end else if (!block) begin
            t        <= t + 1'b1;
            memact   <= 1'b0;
            ctrl.cmd <= cmd_auto_refresh;
          end
          // sit at step 0 while blocked
        end else if (t == last_step) begin
          if (!memcyc)
            t <= first_step;  // wait for cpu to drop strobes
        end else if (!memact && t == capt_step) begin
          t <= first_step;    // refresh done
        end else begin
          t <= t + 1'b1;
        end

        if (memact && t == cas_step)
          ctrl.cmd <= req.rw ? cmd_read : cmd_write;  // a10 set for auto-precharge
        if (memact && t == hold_step)
          ctrl.cke <= !req.rw;  // freeze chip so data stays two clocks
      end
    end
  end

  // ------------------------------
  // steering for addr map and data path
  // ------------------------------
  always_comb begin
    if (!ready)
      phase = init_phase;
    else if (memact && t != first_step && t >= setup_step)
      phase = ph_col;
    else
      phase = ph_row;
  end

  assign mask_load = memact && (t == setup_step);
  assign wr_en     = memact && !req.rw && (t == setup_step || t == cas_step);  // off after cas
  assign rd_strobe = memact && req.rw && (t == capt_step);

endmodule

/* hdl/sdram_top.sv */
/*
  Top level of the single-port SDRAM controller.
  Connects a 68000-style cpu bus to one MT48LC16M16-class chip.
  The chip runs on the inverted system clock.
*/
`timescale 1ns/1ns

module sdram_top #(
  parameter int rcd_cycles  = 2,
  parameter int cas_latency = 3
) (
  input  logic                            clk100_mhz,
  input  logic                            rst,
  // cpu side
  input  logic [sdram_pkg::data_w-1:0]    din,
  output logic [sdram_pkg::data_w-1:0]    dout,
  input  logic [sdram_pkg::addr_w-1:0]    addr,
  input  logic                            udsn,
  input  logic                            ldsn,
  input  logic                            asn,
  input  logic                            rw,
  // chip side
  inout  wire  [sdram_pkg::data_w-1:0]    sd_data,
  output logic [sdram_pkg::sd_addr_w-1:0] sd_addr,
  output logic [1:0]                      sd_dqm,
  output logic [1:0]                      sd_ba,
  output logic                            sd_cs,
  output logic                            sd_we,
  output logic                            sd_ras,
  output logic                            sd_cas,
  output logic                            sd_cke,
  output logic                            sd_clk
);
  import sdram_pkg::*;

  cpu_req_t req;
  sd_ctrl_t ctrl;
  sd_cmd_e  init_cmd;
  phase_e   init_phase;
  phase_e   phase;
  logic     ready;
  logic     wr_en;
  logic     rd_strobe;
  logic     mask_load;

  assign req = '{addr: addr, din: din, udsn: udsn, ldsn: ldsn, asn: asn, rw: rw};

  sdram_init sdram_init_inst (
    .clk100_mhz(clk100_mhz), .rst(rst),
    .cmd(init_cmd), .phase(init_phase), .ready(ready)
  );

  sdram_cycle_ctrl #(.rcd_cycles(rcd_cycles), .cas_latency(cas_latency)) sdram_cycle_ctrl_inst (
    .clk100_mhz(clk100_mhz), .rst(rst), .req(req), .ready(ready),
    .init_cmd(init_cmd), .init_phase(init_phase), .ctrl(ctrl), .phase(phase),
    .wr_en(wr_en), .rd_strobe(rd_strobe), .mask_load(mask_load)
  );

  sdram_addr_map #(.cas_latency(cas_latency)) sdram_addr_map_inst (
    .clk100_mhz(clk100_mhz), .addr(req.addr), .phase(phase),
    .sd_addr(sd_addr), .sd_ba(sd_ba)
  );

  sdram_data_path sdram_data_path_inst (
    .clk100_mhz(clk100_mhz), .rst(rst), .din(req.din),
    .udsn(req.udsn), .ldsn(req.ldsn), .rw(req.rw),
    .wr_en(wr_en), .rd_strobe(rd_strobe), .mask_load(mask_load),
    .sd_data(sd_data), .sd_dqm(sd_dqm), .dout(dout)
  );

  // command word straight onto the control pins
  assign {sd_cs, sd_ras, sd_cas, sd_we} = ctrl.cmd;
  assign sd_cke = ctrl.cke;
  assign sd_clk = ~clk100_mhz;  // 180 deg shift for setup/hold margin

endmodule

/* tests/tb_clock.sv */
/*
  Clock and reset source for the SDRAM testbench.
  100 MHz clock, reset held high for a fixed number of cycles.
*/
`timescale 1ns/1ns

module tb_clock #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 16
) (
  output logic clk100_mhz,
  output logic rst
);

  initial begin
    clk100_mhz = 1'b0;
    forever #(period_ns / 2) clk100_mhz = ~clk100_mhz;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk100_mhz);
    #1 rst = 1'b0;  // released just after an edge
  end

endmodule

/* tests/sdram_model.sv */
/*
  Behavioral model of one x16 SDRAM chip for the testbench.
  Decodes commands on the chip clock, keeps written words in a sparse array
  and counts protocol violations in protocol_errors.
*/
`timescale 1ns/1ns

module sdram_model (
  input  logic        sd_clk,
  input  logic        cke,
  input  logic        cs,
  input  logic        ras,
  input  logic        cas,
  input  logic        we,
  input  logic [1:0]  ba,
  input  logic [12:0] a,
  input  logic [1:0]  dqm,
  inout  wire  [15:0] dq
);
  import sdram_pkg::*;

  logic [15:0] mem [logic [24:0]];  // {bank, row, column}
  logic [12:0] open_row [4];
  logic [3:0]  bank_open;
  logic [2:0]  cas_lat;
  logic        mode_set;
  logic        dq_oe;
  logic [15:0] dq_out;
  logic [15:0] rd_word;
  logic [15:0] word;
  logic [24:0] key;
  int          rd_wait;    // chip clocks until data goes out
  int          drive_cnt;  // clocks left on the bus
  int          protocol_errors;
  sd_cmd_e     cmd;

  assign cmd = sd_cmd_e'({cs, ras, cas, we});
  assign dq  = dq_oe ? dq_out : 'z;

  // unwritten words read back a pattern of the whole location
  function automatic logic [15:0] fill_word(input logic [24:0] k);
    return k[15:0] ^ {7'b0, k[24:16]};
  endfunction

  initial begin
    bank_open       = 4'b0000;
    cas_lat         = 3'd3;
    mode_set        = 1'b0;
    dq_oe           = 1'b0;
    dq_out          = 16'h0000;
    rd_wait         = 0;
    drive_cnt       = 0;
    protocol_errors = 0;
  end

  always @(posedge sd_clk) begin
    if (cke) begin  // clock suspended while cke low
      // ------------------------------
      // read data pipeline
      // ------------------------------
      if (drive_cnt > 0) begin
        drive_cnt--;
        if (drive_cnt == 0)
          dq_oe = 1'b0;
      end
      if (rd_wait > 0) begin
        rd_wait--;
        if (rd_wait == 1) begin  // data out for two clocks
          dq_out    = rd_word;
          dq_oe     = 1'b1;
          drive_cnt = 2;
          rd_wait   = 0;
        end
      end

      // ------------------------------
      // command decode
      // ------------------------------
      key = {ba, open_row[ba], a[9:0]};
      case (cmd)
        cmd_active: begin
          if (!mode_set) begin
            protocol_errors++;
            $display("%0t ns: model got ACTIVE before the mode register was loaded", $time);
          end
          if (bank_open[ba]) begin
            protocol_errors++;
            $display("%0t ns: model got ACTIVE to bank %0d which is already open", $time, ba);
          end
          bank_open[ba] = 1'b1;
          open_row[ba]  = a;
        end
        cmd_write: begin
          if (!bank_open[ba]) begin
            protocol_errors++;
            $display("%0t ns: model got WRITE to closed bank %0d", $time, ba);
          end
          word = mem.exists(key) ? mem[key] : fill_word(key);
          if (!dqm[1])
            word[15:8] = dq[15:8];
          if (!dqm[0])
            word[7:0] = dq[7:0];
          mem[key] = word;
          if (a[10])
            bank_open[ba] = 1'b0;  // auto-precharge
        end
        cmd_read: begin
          if (!bank_open[ba]) begin
            protocol_errors++;
            $display("%0t ns: model got READ from closed bank %0d", $time, ba);
          end
          rd_word = mem.exists(key) ? mem[key] : fill_word(key);
          rd_wait = cas_lat;
          if (a[10])
            bank_open[ba] = 1'b0;
        end
        cmd_precharge: begin
          if (a[10])
            bank_open = 4'b0000;
          else
            bank_open[ba] = 1'b0;
        end
        cmd_auto_refresh: begin
          if (bank_open != 4'b0000) begin
            protocol_errors++;
            $display("%0t ns: model got AUTO REFRESH with a bank still open", $time);
          end
        end
        cmd_load_mode: begin
          cas_lat  = a[6:4];
          mode_set = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

/* tests/tb_sdram.sv */
/*
  Testbench top for the SDRAM controller.
  Drives 68000-style bus cycles, keeps a scoreboard of expected words
  and checks pins, read data and refresh behavior against it.
*/
`timescale 1ns/1ns

module tb_sdram;
  import sdram_pkg::*;

  logic        clk100_mhz;
  logic        rst;
  logic [15:0] din;
  logic [15:0] dout;
  logic [23:0] addr;
  logic        udsn;
  logic        ldsn;
  logic        asn;
  logic        rw;
  wire  [15:0] sd_data;
  logic [12:0] sd_addr;
  logic [1:0]  sd_dqm;
  logic [1:0]  sd_ba;
  logic        sd_cs;
  logic        sd_we;
  logic        sd_ras;
  logic        sd_cas;
  logic        sd_cke;
  logic        sd_clk;

  sd_cmd_e     pin_cmd;
  sd_addr_u    addr_view;
  logic [15:0] sb [logic [23:0]];  // expected word per cpu address
  logic [23:0] written [$];
  int          errors;
  int          pre_count;
  int          mode_count;
  int          refresh_count;
  int          cke_lows;      // cycles with the chip clock suspended
  int          seed;
  logic        seen_active;
  logic        seen_write;
  logic        seen_read;
  logic        blocked_q;     // bus state the DUT saw at the last edge
  logic        expect_write;
  logic        reading;
  logic        dout_valid;
  logic [15:0] exp_dout;
  logic [1:0]  exp_dqm;

  tb_clock tb_clock_inst (.clk100_mhz(clk100_mhz), .rst(rst));

  sdram_top sdram_top_inst (
    .clk100_mhz(clk100_mhz), .rst(rst), .din(din), .dout(dout), .addr(addr),
    .udsn(udsn), .ldsn(ldsn), .asn(asn), .rw(rw),
    .sd_data(sd_data), .sd_addr(sd_addr), .sd_dqm(sd_dqm), .sd_ba(sd_ba),
    .sd_cs(sd_cs), .sd_we(sd_we), .sd_ras(sd_ras), .sd_cas(sd_cas),
    .sd_cke(sd_cke), .sd_clk(sd_clk)
  );

  sdram_model sdram_model_inst (
    .sd_clk(sd_clk), .cke(sd_cke), .cs(sd_cs), .ras(sd_ras), .cas(sd_cas),
    .we(sd_we), .ba(sd_ba), .a(sd_addr), .dqm(sd_dqm), .dq(sd_data)
  );

  assign pin_cmd   = sd_cmd_e'({sd_cs, sd_ras, sd_cas, sd_we});
  assign addr_view = sd_addr;

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERROR %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      errors++;
      $display("%0t ns: %s", $time, what);
    end
  endtask

  task automatic finish_run();
    int total;
    total = errors + sdram_model_inst.protocol_errors;
    $display("summary: %0d testbench errors, %0d model errors",
             errors, sdram_model_inst.protocol_errors);
    if (total == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  endtask

  // ------------------------------
  // command monitor at mid cycle
  // ------------------------------
  always @(posedge clk100_mhz) blocked_q <= !asn && udsn && ldsn;

  always @(negedge clk100_mhz) begin
    if (!rst) begin
      if (!sd_cke)
        cke_lows++;
      case (pin_cmd)
        cmd_precharge: if (!seen_active) begin
          pre_count++;
          check_true(sd_addr[10], "init precharge without a10 set");
        end
        cmd_load_mode: begin
          mode_count++;
          check_true(pre_count == 1, "mode register loaded before the precharge");
          check_value("mode cas_lat", 16'd3, 16'(addr_view.mode.cas_lat));
          check_value("mode burst_len", 16'd1, 16'(addr_view.mode.burst_len));
          check_value("mode write_burst", 16'd1, 16'(addr_view.mode.write_burst));
        end
        cmd_active: begin
          check_value("sd_ba", 16'(addr[21:20]), 16'(sd_ba));
          if (!seen_active) begin
            check_true(pre_count == 1 && mode_count == 1, "ACTIVE before a complete init");
            seen_active = 1'b1;
          end
        end
        cmd_auto_refresh: begin
          refresh_count++;
          check_true(!blocked_q, "auto refresh issued while a write was being set up");
        end
        cmd_write: begin
          seen_write = 1'b1;
          check_value("sd_dqm", 16'(exp_dqm), 16'(sd_dqm));
          check_value("sd_ba", 16'(addr[21:20]), 16'(sd_ba));
        end
        cmd_read: begin
          seen_read = 1'b1;
          check_value("sd_dqm", 16'd0, 16'(sd_dqm));
          check_value("sd_ba", 16'(addr[21:20]), 16'(sd_ba));
        end
        default: ;
      endcase
    end
  end

  // bus hygiene well clear of both edges
  always begin
    @(negedge clk100_mhz);
    #2;
    if (!rst) begin
      check_true(sd_clk === 1'b1, "sd_clk is not the inverted system clock");
      if (expect_write)
        check_true(pin_cmd == cmd_write, "controller drove sd_data with no WRITE following");
      expect_write = 1'b0;
      if (!sdram_model_inst.dq_oe && sd_data !== 16'hzzzz && pin_cmd != cmd_write)
        expect_write = 1'b1;  // setup cycle so WRITE must come next
      if (dout_valid && !reading)
        check_value("dout", exp_dout, dout);
    end
  end

  // ------------------------------
  // cpu bus cycles
  // ------------------------------
  task automatic cpu_write(input logic [23:0] a, input logic [15:0] d,
                           input logic u, input logic l);
    int          n;
    logic [15:0] w;
    @(posedge clk100_mhz);
    #1;
    cke_lows = 0;
    addr = a;
    din  = d;
    rw   = 1'b0;
    asn  = 1'b0;  // strobes still high so refresh is held off
    repeat (4) @(posedge clk100_mhz);
    #1;
    exp_dqm    = {u, l};
    seen_write = 1'b0;
    udsn       = u;
    ldsn       = l;
    n = 0;
    while (!seen_write && n < 40) begin
      @(posedge clk100_mhz);
      n++;
    end
    check_true(seen_write, "no WRITE command after the strobes went low");
    repeat (4) @(posedge clk100_mhz);  // past the cke step
    #1;
    asn  = 1'b1;
    udsn = 1'b1;
    ldsn = 1'b1;
    rw   = 1'b1;
    check_true(cke_lows == 0, "sd_cke went low during a write cycle");
    w = sb.exists(a) ? sb[a] : 16'h0000;
    if (!u)
      w[15:8] = d[15:8];  // merge only strobed bytes
    if (!l)
      w[7:0] = d[7:0];
    if (!sb.exists(a))
      written.push_back(a);
    sb[a] = w;
  endtask

  task automatic cpu_read(input logic [23:0] a);
    int n;
    @(posedge clk100_mhz);
    #1;
    reading   = 1'b1;
    seen_read = 1'b0;
    cke_lows  = 0;
    addr = a;
    rw   = 1'b1;
    asn  = 1'b0;
    udsn = 1'b0;
    ldsn = 1'b0;
    n = 0;
    while (!seen_read && n < 40) begin
      @(posedge clk100_mhz);
      n++;
    end
    check_true(seen_read, "no READ command during a read cycle");
    repeat (5) @(posedge clk100_mhz);  // capture is four edges after READ
    #1;
    check_value("dout", sb[a], dout);
    check_true(cke_lows == 1, "sd_cke was not low for exactly one cycle during the read");
    exp_dout   = sb[a];
    dout_valid = 1'b1;
    asn  = 1'b1;
    udsn = 1'b1;
    ldsn = 1'b1;
    @(posedge clk100_mhz);
    #1;
    reading = 1'b0;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    logic [23:0] a;
    logic [31:0] r;
    logic [31:0] r2;
    logic        u;
    logic        l;
    int          n;
    din = 16'h0000;
    addr = 24'h000000;
    udsn = 1'b1;
    ldsn = 1'b1;
    asn = 1'b1;
    rw = 1'b1;
    errors = 0;
    pre_count = 0;
    mode_count = 0;
    refresh_count = 0;
    cke_lows = 0;
    seen_active = 1'b0;
    seen_write = 1'b0;
    seen_read = 1'b0;
    expect_write = 1'b0;
    reading = 1'b0;
    dout_valid = 1'b0;
    exp_dout = 16'h0000;
    exp_dqm = 2'b00;
    seed = 32'h8f0fdd60;

    n = 0;
    while (rst !== 1'b0 && n < 100) begin
      @(posedge clk100_mhz);
      n++;
    end
    check_true(rst === 1'b0, "reset was never released");
    n = 0;
    while (refresh_count == 0 && n < 100) begin  // first refresh marks ready
      @(posedge clk100_mhz);
      n++;
    end
    check_true(refresh_count > 0, "no auto refresh after power-up");
    check_true(pre_count == 1 && mode_count == 1, "init sequence incomplete");

    // full words over banks, rows, columns
    cpu_write(24'h012345, 16'h1234, 1'b0, 1'b0);
    cpu_write(24'h134a67, 16'h5678, 1'b0, 1'b0);
    cpu_write(24'h4fff00, 16'h9abc, 1'b0, 1'b0);
    cpu_write(24'h2abcde, 16'hdef0, 1'b0, 1'b0);
    cpu_read(24'h012345);
    cpu_read(24'h134a67);
    cpu_read(24'h4fff00);
    cpu_read(24'h2abcde);

    // byte lanes
    cpu_write(24'h012345, 16'hab00, 1'b0, 1'b1);
    cpu_write(24'h134a67, 16'h00cd, 1'b1, 1'b0);
    cpu_read(24'h012345);
    cpu_read(24'h134a67);

    // idle refresh and then blocked by write setup
    n = refresh_count;
    repeat (40) @(posedge clk100_mhz);
    check_true(refresh_count - n >= 4, "too few refreshes while the bus was idle");
    #1;
    asn = 1'b0;
    rw  = 1'b0;
    repeat (10) @(posedge clk100_mhz);
    n = refresh_count;
    repeat (20) @(posedge clk100_mhz);
    check_true(refresh_count == n, "refresh issued while asn was low with strobes high");
    #1;
    asn = 1'b1;
    rw  = 1'b1;

    // random traffic
    for (int i = 0; i < 40; i++) begin
      r  = $random(seed);
      r2 = $random(seed);
      if (written.size() == 0 || r[0]) begin
        if (r[1] && written.size() != 0)
          a = written[r[15:8] % written.size()];  // revisit a known word
        else
          a = {1'b0, r2[22:0]};
        u = sb.exists(a) ? r[2] : 1'b0;
        l = sb.exists(a) ? r[3] : 1'b0;
        if (u && l)
          l = 1'b0;
        cpu_write(a, r2[31:16], u, l);
      end else begin
        cpu_read(written[r[15:8] % written.size()]);
      end
    end

    repeat (20) @(posedge clk100_mhz);
    finish_run();
  end

  // hang guard
  initial begin
    repeat (50000) @(posedge clk100_mhz);
    $display("simulation did not finish within its time limit");
    errors++;
    finish_run();
  end

endmodule

/* tb.f */
hdl/sdram_pkg.sv
hdl/sdram_init.sv
hdl/sdram_addr_map.sv
hdl/sdram_data_path.sv
hdl/sdram_cycle_ctrl.sv
hdl/sdram_top.sv
tests/tb_clock.sv
tests/sdram_model.sv
tests/tb_sdram.sv
